// ==== rtl/rdma_mem_pkg.sv ====
// --------------------------------------------------
// Memory side types of the send-queue front end.
// Address and length widths and the request struct
// driven on the local memory read and write ports.
// --------------------------------------------------
package rdma_mem_pkg;

  // Virtual address and transfer length widths
  localparam int VADDR_BITS = 48;
  localparam int LEN_BITS = 28;

  // Queue pair tag carried back with each request
  localparam int MEM_QPN_BITS = 10;

  // One local memory request, read or write
  typedef struct packed {
    logic [VADDR_BITS-1:0]   vaddr;
    logic [LEN_BITS-1:0]     len;
    logic                    host;
    logic [MEM_QPN_BITS-1:0] qpn;
  } mem_req_t;

endpackage

// ==== rtl/rdma_cmd_pkg.sv ====
// --------------------------------------------------
// User side types of the send-queue front end.
// Opcodes, the send-queue command and the completion
// acknowledgement returned to the user.
// --------------------------------------------------
package rdma_cmd_pkg;

  import rdma_mem_pkg::*;

  // Queue pair number width
  localparam int QPN_BITS = 10;

  // Command opcodes
  typedef enum logic [3:0] {
    OP_RDMA_WRITE = 4'h0,
    OP_RDMA_READ  = 4'h1,
    // Not handled by this front end, answered with a NAK
    OP_SEND       = 4'h2
  } rdma_opcode_e;

  // One send-queue command
  typedef struct packed {
    rdma_opcode_e          opcode;
    logic [QPN_BITS-1:0]   qpn;
    // Host memory when set, card memory otherwise
    logic                  host;
    logic [VADDR_BITS-1:0] laddr;
    logic [LEN_BITS-1:0]   len;
  } sq_cmd_t;

  // Completion for one command
  typedef struct packed {
    logic [QPN_BITS-1:0] qpn;
    logic                is_nak;
  } rdma_ack_t;

endpackage

// ==== rtl/sq_admit.sv ====
// --------------------------------------------------
// Admission stage for the send queue.
// Counts commands in flight and holds back new ones
// once max_outstanding acks are still pending.
// --------------------------------------------------
module sq_admit import rdma_cmd_pkg::*; #(
  parameter int unsigned max_outstanding = 4
) (
  input  logic    nclk,
  input  logic    nresetn,
  // Command queue from the user
  input  logic    sq_valid,
  input  sq_cmd_t sq_data,
  output logic    sq_ready,
  // Admitted commands
  output logic    out_valid,
  output sq_cmd_t out_data,
  input  logic    out_ready,
  // Ack channel, observed only
  input  logic    ack_valid,
  input  logic    ack_ready
);

  localparam int cnt_bits = $clog2(max_outstanding + 1);
  localparam logic [cnt_bits-1:0] cnt_max = cnt_bits'(max_outstanding);

  logic [cnt_bits-1:0] count;
  logic                admit_ok;
  logic                cmd_fire;
  logic                ack_fire;

  assign admit_ok = count < cnt_max;

  // Both halves of the handshake gated by the credit check
  assign out_valid = sq_valid & admit_ok;
  assign sq_ready  = out_ready & admit_ok;
  assign out_data  = sq_data;

  assign cmd_fire = sq_valid & sq_ready;
  assign ack_fire = ack_valid & ack_ready;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      count <= '0;
    end else begin
      case ({cmd_fire, ack_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Accept and retire together leave the count as is
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/sq_fifo.sv ====
// --------------------------------------------------
// Synchronous FIFO for admitted send-queue commands.
// Circular buffer of depth entries; a pushed entry
// is visible on the output one cycle after the push.
// --------------------------------------------------
module sq_fifo import rdma_cmd_pkg::*; #(
  parameter int unsigned depth = 4
) (
  input  logic    nclk,
  input  logic    nresetn,
  input  logic    in_valid,
  input  sq_cmd_t in_data,
  output logic    in_ready,
  output logic    out_valid,
  output sq_cmd_t out_data,
  input  logic    out_ready
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);
  localparam logic [ptr_bits-1:0] ptr_last = ptr_bits'(depth - 1);
  localparam logic [cnt_bits-1:0] cnt_full = cnt_bits'(depth);

  sq_cmd_t             mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push;
  logic                pop;

  assign in_ready  = count != cnt_full;
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage, no reset needed on payload
  always_ff @(posedge nclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/rdma_req_engine.sv ====
// --------------------------------------------------
// Request engine of the send queue.
// Takes one command at a time, issues the local memory
// request it needs and then its completion ack.
// --------------------------------------------------
module rdma_req_engine import rdma_cmd_pkg::*, rdma_mem_pkg::*; (
  input  logic      nclk,
  input  logic      nresetn,
  // Commands from the FIFO
  input  logic      cmd_valid,
  input  sq_cmd_t   cmd_data,
  output logic      cmd_ready,
  // Local memory read, used by RDMA write
  output logic      mem_rd_valid,
  output mem_req_t  mem_rd_data,
  input  logic      mem_rd_ready,
  // Local memory write, used by RDMA read
  output logic      mem_wr_valid,
  output mem_req_t  mem_wr_data,
  input  logic      mem_wr_ready,
  // Completions
  output logic      ack_valid,
  output rdma_ack_t ack_data,
  input  logic      ack_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_ACK
  } state_e;

  state_e    state;
  mem_req_t  req_q;
  rdma_ack_t ack_q;
  logic      sel_rd;
  logic      cmd_fire;
  logic      mem_fire;
  logic      cmd_ok;
  logic      cmd_is_wr;

  assign cmd_ready = state == ST_IDLE;
  assign cmd_fire  = cmd_valid & cmd_ready;

  // Decode of the incoming command
  assign cmd_is_wr = cmd_data.opcode == OP_RDMA_WRITE;
  assign cmd_ok = (cmd_is_wr || cmd_data.opcode == OP_RDMA_READ) && cmd_data.len != '0;

  assign mem_rd_valid = (state == ST_MEM) & sel_rd;
  assign mem_wr_valid = (state == ST_MEM) & ~sel_rd;
  assign mem_rd_data  = req_q;
  assign mem_wr_data  = req_q;
  assign mem_fire = sel_rd ? mem_rd_valid & mem_rd_ready : mem_wr_valid & mem_wr_ready;

  assign ack_valid = state == ST_ACK;
  assign ack_data  = ack_q;

  // Command capture
  always_ff @(posedge nclk) begin
    if (cmd_fire) begin
      req_q.vaddr   <= cmd_data.laddr;
      req_q.len     <= cmd_data.len;
      req_q.host    <= cmd_data.host;
      req_q.qpn     <= cmd_data.qpn;
      ack_q.qpn     <= cmd_data.qpn;
      ack_q.is_nak  <= ~cmd_ok;
      // An RDMA write pulls its payload from local memory
      sel_rd        <= cmd_is_wr;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            state <= cmd_ok ? ST_MEM : ST_ACK;
          end
        end
        ST_MEM: begin
          if (mem_fire) begin
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (ack_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/roce_cmd_top.sv ====
// --------------------------------------------------
// Send-queue front end top level.
// Chains admission, command FIFO and request engine;
// acks are fed back to admission to return credits.
// --------------------------------------------------
module roce_cmd_top import rdma_cmd_pkg::*, rdma_mem_pkg::*; #(
  parameter int unsigned max_outstanding = 4,
  parameter int unsigned fifo_depth = 4
) (
  input  logic      nclk,
  input  logic      nresetn,
  // User command queue
  input  logic      sq_valid,
  input  sq_cmd_t   sq_data,
  output logic      sq_ready,
  // Memory requests
  output logic      mem_rd_valid,
  output mem_req_t  mem_rd_data,
  input  logic      mem_rd_ready,
  output logic      mem_wr_valid,
  output mem_req_t  mem_wr_data,
  input  logic      mem_wr_ready,
  // Completions
  output logic      ack_valid,
  output rdma_ack_t ack_data,
  input  logic      ack_ready
);

  logic    admit_valid;
  sq_cmd_t admit_data;
  logic    admit_ready;
  logic    fifo_valid;
  sq_cmd_t fifo_data;
  logic    fifo_ready;

  sq_admit #(
    .max_outstanding(max_outstanding)
  ) u_sq_admit (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .sq_valid  (sq_valid),
    .sq_data   (sq_data),
    .sq_ready  (sq_ready),
    .out_valid (admit_valid),
    .out_data  (admit_data),
    .out_ready (admit_ready),
    .ack_valid (ack_valid),
    .ack_ready (ack_ready)
  );

  sq_fifo #(
    .depth(fifo_depth)
  ) u_sq_fifo (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .in_valid  (admit_valid),
    .in_data   (admit_data),
    .in_ready  (admit_ready),
    .out_valid (fifo_valid),
    .out_data  (fifo_data),
    .out_ready (fifo_ready)
  );

  rdma_req_engine u_rdma_req_engine (
    .nclk         (nclk),
    .nresetn      (nresetn),
    .cmd_valid    (fifo_valid),
    .cmd_data     (fifo_data),
    .cmd_ready    (fifo_ready),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_ready (mem_rd_ready),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_ready (mem_wr_ready),
    .ack_valid    (ack_valid),
    .ack_data     (ack_data),
    .ack_ready    (ack_ready)
  );

endmodule

// ==== test/roce_cmd_assert.sv ====
// --------------------------------------------------
// Concurrent checks on the admission credit counter.
// Bound into every sq_admit instance.
// --------------------------------------------------
module roce_cmd_assert #(
  parameter int unsigned max_outstanding = 4
) (
  input logic                                   nclk,
  input logic                                   nresetn,
  input logic [$clog2(max_outstanding + 1)-1:0] count,
  input logic                                   sq_valid,
  input logic                                   sq_ready,
  input logic                                   ack_valid,
  input logic                                   ack_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cnt_bits = $clog2(max_outstanding + 1);
  localparam logic [cnt_bits-1:0] cnt_max = cnt_bits'(max_outstanding);

  count_in_range: assert property (@(posedge nclk) disable iff (!nresetn)
    count <= cnt_max)
    else $error("admission count above max_outstanding");

  // An ack with nothing outstanding would wrap the counter
  no_underflow: assert property (@(posedge nclk) disable iff (!nresetn)
    (count == '0) |-> !(ack_valid && ack_ready && !(sq_valid && sq_ready)))
    else $error("ack retired while no command was outstanding");

endmodule

bind sq_admit roce_cmd_assert #(
  .max_outstanding(max_outstanding)
) u_admit_assert (
  .nclk      (nclk),
  .nresetn   (nresetn),
  .count     (count),
  .sq_valid  (sq_valid),
  .sq_ready  (sq_ready),
  .ack_valid (ack_valid),
  .ack_ready (ack_ready)
);

// ==== test/roce_cmd_checker.sv ====
// --------------------------------------------------
// Scoreboard for the send-queue front end.
// Queues accepted commands and compares every memory
// request and ack transfer with the expected values.
// --------------------------------------------------
module roce_cmd_checker import rdma_cmd_pkg::*, rdma_mem_pkg::*; (
  input  logic      nclk,
  input  logic      nresetn,
  input  logic      sq_valid,
  input  sq_cmd_t   sq_data,
  input  logic      sq_ready,
  input  logic      mem_rd_valid,
  input  mem_req_t  mem_rd_data,
  input  logic      mem_rd_ready,
  input  logic      mem_wr_valid,
  input  mem_req_t  mem_wr_data,
  input  logic      mem_wr_ready,
  input  logic      ack_valid,
  input  rdma_ack_t ack_data,
  input  logic      ack_ready,
  output int        err_cnt,
  output int        acc_cnt,
  output int        ack_cnt,
  output int        rd_cnt,
  output int        wr_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int port_none = 0;
  localparam int port_rd = 1;
  localparam int port_wr = 2;

  sq_cmd_t pend[$];
  logic    mem_seen;

  // Expected behavior of one command
  function automatic void expect_cmd(input sq_cmd_t c, output int port,
                                     output mem_req_t req, output rdma_ack_t ack);
    port = port_none;
    if (c.len != '0) begin
      // RDMA write reads local memory, RDMA read writes it
      if (c.opcode == OP_RDMA_WRITE) begin
        port = port_rd;
      end else if (c.opcode == OP_RDMA_READ) begin
        port = port_wr;
      end
    end
    req.vaddr = c.laddr;
    req.len = c.len;
    req.host = c.host;
    req.qpn = c.qpn;
    ack.qpn = c.qpn;
    ack.is_nak = port == port_none;
  endfunction

  task automatic check_mem(input string name, input logic allowed,
                           input mem_req_t exp, input mem_req_t got);
    if (!allowed) begin
      $display("ERROR t=%0t request on %s not expected for the pending command", $time, name);
      err_cnt++;
    end else if (mem_seen) begin
      $display("ERROR t=%0t second request on %s for one command", $time, name);
      err_cnt++;
    end else if (got !== exp) begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
      err_cnt++;
    end
    mem_seen = 1'b1;
  endtask

  always @(posedge nclk) begin
    int        port;
    mem_req_t  exp_req;
    rdma_ack_t exp_ack;
    if (!nresetn) begin
      pend.delete();
      mem_seen = 1'b0;
    end else begin
      port = -1;
      exp_req = '0;
      exp_ack = '0;
      if (pend.size() != 0) begin
        expect_cmd(pend[0], port, exp_req, exp_ack);
      end
      if (mem_rd_valid && mem_rd_ready) begin
        rd_cnt++;
        check_mem("mem_rd_data", port == port_rd, exp_req, mem_rd_data);
      end
      if (mem_wr_valid && mem_wr_ready) begin
        wr_cnt++;
        check_mem("mem_wr_data", port == port_wr, exp_req, mem_wr_data);
      end
      if (ack_valid && ack_ready) begin
        ack_cnt++;
        if (port < 0) begin
          $display("ERROR t=%0t ack sent with no command pending", $time);
          err_cnt++;
        end else begin
          if (port != port_none && !mem_seen) begin
            $display("ERROR t=%0t ack sent before its memory request", $time);
            err_cnt++;
          end
          if (ack_data !== exp_ack) begin
            $display("MISMATCH t=%0t ack_data expected %h got %h", $time, exp_ack, ack_data);
            err_cnt++;
          end
          void'(pend.pop_front());
          mem_seen = 1'b0;
        end
      end
      // New commands join the tail after this edge's retirements
      if (sq_valid && sq_ready) begin
        pend.push_back(sq_data);
        acc_cnt++;
      end
    end
  end

endmodule

// ==== test/tb_roce_cmd.sv ====
// --------------------------------------------------
// Testbench for the send-queue front end.
// Directed opcode and credit tests, then a random run
// under back-pressure, scored by roce_cmd_checker.
// --------------------------------------------------
module tb_roce_cmd import rdma_cmd_pkg::*, rdma_mem_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_out = 4;
  localparam int total_cmds = 209;
  localparam int cycle_limit = 200 * total_cmds + 500;

  logic      nclk;
  logic      nresetn;
  logic      sq_valid;
  sq_cmd_t   sq_data;
  logic      sq_ready;
  logic      mem_rd_valid;
  mem_req_t  mem_rd_data;
  logic      mem_rd_ready;
  logic      mem_wr_valid;
  mem_req_t  mem_wr_data;
  logic      mem_wr_ready;
  logic      ack_valid;
  rdma_ack_t ack_data;
  logic      ack_ready;

  int   err_cnt, acc_cnt, ack_cnt, rd_cnt, wr_cnt;
  int   local_errs, base_errs, rd0, wr0, ack0;
  int   tests_run, tests_bad, cycles, got;
  logic rand_ready;

  roce_cmd_top #(
    .max_outstanding(max_out),
    .fifo_depth(4)
  ) u_roce_cmd_top (
    .nclk(nclk), .nresetn(nresetn),
    .sq_valid(sq_valid), .sq_data(sq_data), .sq_ready(sq_ready),
    .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data), .mem_rd_ready(mem_rd_ready),
    .mem_wr_valid(mem_wr_valid), .mem_wr_data(mem_wr_data), .mem_wr_ready(mem_wr_ready),
    .ack_valid(ack_valid), .ack_data(ack_data), .ack_ready(ack_ready)
  );

  roce_cmd_checker u_checker (
    .nclk(nclk), .nresetn(nresetn),
    .sq_valid(sq_valid), .sq_data(sq_data), .sq_ready(sq_ready),
    .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data), .mem_rd_ready(mem_rd_ready),
    .mem_wr_valid(mem_wr_valid), .mem_wr_data(mem_wr_data), .mem_wr_ready(mem_wr_ready),
    .ack_valid(ack_valid), .ack_data(ack_data), .ack_ready(ack_ready),
    .err_cnt(err_cnt), .acc_cnt(acc_cnt), .ack_cnt(ack_cnt),
    .rd_cnt(rd_cnt), .wr_cnt(wr_cnt)
  );

  initial begin
    nclk = 1'b0;
    forever begin
      #10 nclk = ~nclk;
    end
  end

  // Random ready, changed only while rand_ready is set
  initial begin
    forever begin
      @(posedge nclk);
      #2;
      if (rand_ready) begin
        mem_rd_ready = ($urandom % 4) != 0;
        mem_wr_ready = ($urandom % 4) != 0;
        ack_ready = ($urandom % 3) != 0;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge nclk);
      cycles++;
    end
    $display("ERROR t=%0t timeout after %0d cycles, the DUT stopped making progress",
             $time, cycles);
    $display("tests failed");
    $finish;
  end

  function automatic sq_cmd_t build_cmd(input rdma_opcode_e op, input logic [27:0] len);
    sq_cmd_t c;
    c.opcode = op;
    c.qpn = 10'($urandom);
    c.host = 1'($urandom);
    c.laddr = {16'($urandom), $urandom};
    c.len = len;
    return c;
  endfunction

  function automatic sq_cmd_t rand_cmd();
    int           r;
    rdma_opcode_e op;
    logic [27:0]  len;
    r = $urandom % 8;
    if (r < 3) begin
      op = OP_RDMA_WRITE;
    end else if (r < 6) begin
      op = OP_RDMA_READ;
    end else begin
      op = OP_SEND;
    end
    len = 28'($urandom % 4096 + 1);
    // Roughly one in eight goes out with zero length
    if ($urandom % 8 == 0) begin
      len = '0;
    end
    return build_cmd(op, len);
  endfunction

  // Entered and left 2 ns after a rising edge
  task automatic send_cmd(input sq_cmd_t c);
    sq_data = c;
    sq_valid = 1'b1;
    @(negedge nclk);
    while (!sq_ready) begin
      @(negedge nclk);
    end
    @(posedge nclk);
    #2;
    sq_valid = 1'b0;
  endtask

  // Keeps offering writes for n cycles and counts the accepts
  task automatic offer_for(input int n, output int accepted);
    logic took;
    accepted = 0;
    sq_data = build_cmd(OP_RDMA_WRITE, 28'd64);
    sq_valid = 1'b1;
    repeat (n) begin
      @(negedge nclk);
      took = sq_ready;
      @(posedge nclk);
      #2;
      if (took) begin
        accepted++;
        sq_data = build_cmd(OP_RDMA_WRITE, 28'd64);
      end
    end
    sq_valid = 1'b0;
  endtask

  // Waits for the acks of all accepted commands, bounded per pending command
  task automatic drain();
    int limit;
    int waited;
    limit = 200 * (acc_cnt - ack_cnt) + 100;
    waited = 0;
    @(negedge nclk);
    while (ack_cnt != acc_cnt && waited < limit) begin
      @(negedge nclk);
      waited++;
    end
    @(posedge nclk);
    #2;
  endtask

  task automatic start_test();
    base_errs = err_cnt + local_errs;
    rd0 = rd_cnt;
    wr0 = wr_cnt;
    ack0 = ack_cnt;
  endtask

  task automatic check_count(input string name, input int exp, input int actual);
    if (exp != actual) begin
      $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, actual);
      local_errs++;
    end
  endtask

  task automatic check_traffic(input int n_rd, input int n_wr, input int n_ack);
    check_count("mem_rd transfers", n_rd, rd_cnt - rd0);
    check_count("mem_wr transfers", n_wr, wr_cnt - wr0);
    check_count("ack transfers", n_ack, ack_cnt - ack0);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt + local_errs != base_errs) begin
      tests_bad++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    void'($urandom(18));
    nresetn = 1'b0;
    sq_valid = 1'b0;
    sq_data = '0;
    mem_rd_ready = 1'b1;
    mem_wr_ready = 1'b1;
    ack_ready = 1'b1;
    rand_ready = 1'b0;
    local_errs = 0;
    tests_run = 0;
    tests_bad = 0;
    repeat (10) @(posedge nclk);
    #2;
    nresetn = 1'b1;

    start_test();
    send_cmd(build_cmd(OP_RDMA_WRITE, 28'd256));
    drain();
    check_traffic(1, 0, 1);
    end_test("single rdma write");

    start_test();
    send_cmd(build_cmd(OP_RDMA_READ, 28'd4096));
    drain();
    check_traffic(0, 1, 1);
    end_test("single rdma read");

    start_test();
    send_cmd(build_cmd(OP_SEND, 28'd128));
    send_cmd(build_cmd(OP_RDMA_WRITE, 28'd0));
    drain();
    check_traffic(0, 0, 2);
    end_test("nak for send and zero length");

    // Credit limit with the ack channel blocked
    start_test();
    ack_ready = 1'b0;
    offer_for(30, got);
    check_count("accepted commands", max_out, got);
    @(negedge nclk);
    if (sq_ready) begin
      $display("ERROR t=%0t sq_ready high with all credits in use", $time);
      local_errs++;
    end
    @(posedge nclk);
    #2;
    ack_ready = 1'b1;
    @(posedge nclk);
    #2;
    ack_ready = 1'b0;
    offer_for(30, got);
    check_count("accepted after one ack", 1, got);
    ack_ready = 1'b1;
    drain();
    check_traffic(max_out + 1, 0, max_out + 1);
    end_test("credit limit");

    start_test();
    @(negedge nclk);
    rand_ready = 1'b1;
    @(posedge nclk);
    #2;
    for (int i = 0; i < 200; i++) begin
      send_cmd(rand_cmd());
    end
    drain();
    check_count("ack count", acc_cnt, ack_cnt);
    @(negedge nclk);
    rand_ready = 1'b0;
    end_test("random mix under back-pressure");

    $display("%0d tests run, %0d failing, %0d commands accepted, %0d acks, %0d errors",
             tests_run, tests_bad, acc_cnt, ack_cnt, err_cnt + local_errs);
    if (tests_bad == 0 && err_cnt + local_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/rdma_mem_pkg.sv
rtl/rdma_cmd_pkg.sv
rtl/sq_admit.sv
rtl/sq_fifo.sv
rtl/rdma_req_engine.sv
rtl/roce_cmd_top.sv
test/roce_cmd_assert.sv
test/roce_cmd_checker.sv
test/tb_roce_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Compile the send-queue front end with Verilator and run its testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_roce_cmd -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build step failed"
  exit 1
fi

out=$(./obj_dir/Vtb_roce_cmd)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
